/* hdl/soc_pkg.sv */
package soc_pkg;

    // bus address, seen either as the raw word or split into fields
    typedef union packed {
        logic [31:0] word;
        struct packed {
            logic [3:0]  region;
            logic [19:0] unused;
            logic [7:0]  offset;
        } f;
    } bus_addr_u;

    ////////////////////
    // memory map
    ////////////////////
    localparam logic [3:0] REGION_RAM_MAX = 4'h1;  // regions 0 and 1
    localparam logic [3:0] REGION_TIMER   = 4'h2;
    localparam logic [3:0] REGION_IRQ_MAX = 4'h7;  // 3 to 7, peripherals above

    localparam int RAM_WORDS    = 64;
    localparam int RAM_AW       = $clog2(RAM_WORDS);
    localparam int CLKS_PER_BIT = 8;
    localparam int BAUD_CNT_W   = $clog2(CLKS_PER_BIT);
    localparam int IRQ_COUNT    = 2;                  // 1 uart done, 2 button
    localparam int IRQ_ID_W     = $clog2(IRQ_COUNT + 1);

    ////////////////////
    // register offsets
    ////////////////////
    localparam logic [7:0] MTIME_LO    = 8'h00;
    localparam logic [7:0] MTIME_HI    = 8'h04;
    localparam logic [7:0] MTIMECMP_LO = 8'h08;
    localparam logic [7:0] MTIMECMP_HI = 8'h0C;

    localparam logic [7:0] IRQ_ENABLE  = 8'h00;
    localparam logic [7:0] IRQ_PENDING = 8'h04;
    localparam logic [7:0] IRQ_CLAIM   = 8'h08;

    localparam logic [7:0] UART_DATA   = 8'h00;
    localparam logic [7:0] UART_STATUS = 8'h04;
    localparam logic [7:0] BUTTON      = 8'h08;

    // uart transmitter states
    localparam logic [1:0] TX_IDLE  = 2'd0;
    localparam logic [1:0] TX_START = 2'd1;
    localparam logic [1:0] TX_DATA  = 2'd2;
    localparam logic [1:0] TX_STOP  = 2'd3;

endpackage

/* hdl/baud_timer.sv */
module baud_timer
    import soc_pkg::*;
(
    input  logic clk,
    input  logic arst_n_i,
    input  logic run_i,
    output logic tick_o
);

    logic [BAUD_CNT_W-1:0] cnt;
    logic                  last;

    assign last   = (cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1));
    assign tick_o = run_i && last;  // one tick per bit period

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt <= '0;
        end else if (!run_i || last) begin
            cnt <= '0;  // held at zero while idle
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

/* hdl/uart_tx_fsm.sv */
module uart_tx_fsm
    import soc_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n_i,
    input  logic       start_i,
    input  logic [7:0] data_i,
    output logic       tx_o,
    output logic       busy_o,
    output logic       done_o
);

    logic [1:0] state;
    logic [2:0] bit_idx;
    logic [7:0] shift;
    logic       tick;

    assign busy_o = (state != TX_IDLE);

    baud_timer u_baud (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .run_i    (busy_o),
        .tick_o   (tick)
    );

    ////////////////////
    // frame sequencer
    ////////////////////
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state   <= TX_IDLE;
            bit_idx <= '0;
            tx_o    <= 1'b1;   // line idles high
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state)
                TX_IDLE: begin
                    if (start_i) begin
                        tx_o  <= 1'b0;   // start bit
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    if (tick) begin
                        tx_o    <= shift[0];
                        bit_idx <= '0;
                        state   <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (tick) begin
                        if (bit_idx == 3'd7) begin
                            tx_o  <= 1'b1;   // stop bit
                            state <= TX_STOP;
                        end else begin
                            tx_o    <= shift[0];
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                default: begin
                    if (tick) begin
                        done_o <= 1'b1;
                        state  <= TX_IDLE;
                    end
                end
            endcase
        end
    end

    // payload shift, lsb first
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && start_i) begin
            shift <= data_i;
        end else if (tick && state != TX_STOP) begin
            shift <= {1'b0, shift[7:1]};
        end
    end

endmodule

/* hdl/periph_regs.sv */
module periph_regs
    import soc_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n_i,
    input  logic        en_i,
    input  logic [3:0]  we_i,
    input  bus_addr_u   addr_i,
    input  logic [31:0] wdata_i,
    output logic [31:0] rdata_o,
    input  logic        btn_i,
    output logic        tx_o,
    output logic        uart_done_o,
    output logic        btn_press_o
);

    logic [7:0] tx_data;
    logic       tx_start, tx_busy, uart_busy;
    logic       btn_meta, btn_sync, btn_last;

    // start pulse counts as busy so back to back writes are dropped
    assign uart_busy = tx_busy | tx_start;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tx_start <= 1'b0;
        end else begin
            tx_start <= en_i && (we_i != 4'h0) && addr_i.f.offset == UART_DATA && !uart_busy;
        end
    end

    always_ff @(posedge clk) begin
        if (en_i && (we_i != 4'h0) && addr_i.f.offset == UART_DATA && !uart_busy) begin
            tx_data <= wdata_i[7:0];
        end
    end

    uart_tx_fsm u_tx (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .start_i  (tx_start),
        .data_i   (tx_data),
        .tx_o     (tx_o),
        .busy_o   (tx_busy),
        .done_o   (uart_done_o)
    );

    ////////////////////
    // button sync and edge
    ////////////////////
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            btn_meta    <= 1'b0;
            btn_sync    <= 1'b0;
            btn_last    <= 1'b0;
            btn_press_o <= 1'b0;
        end else begin
            btn_meta    <= btn_i;
            btn_sync    <= btn_meta;
            btn_last    <= btn_sync;
            btn_press_o <= btn_sync && !btn_last;  // rising edge only
        end
    end

    always_ff @(posedge clk) begin
        if (en_i) begin
            case (addr_i.f.offset)
                UART_DATA:   rdata_o <= {24'h0, tx_data};
                UART_STATUS: rdata_o <= {31'h0, uart_busy};
                BUTTON:      rdata_o <= {31'h0, btn_sync};
                default:     rdata_o <= '0;
            endcase
        end
    end

endmodule

/* hdl/scratch_ram.sv */
module scratch_ram
    import soc_pkg::*;
(
    input  logic        clk,
    input  logic        en_i,
    input  logic [3:0]  we_i,
    input  bus_addr_u   addr_i,
    input  logic [31:0] wdata_i,
    output logic [31:0] rdata_o
);

    logic [31:0]       mem [RAM_WORDS];
    logic [RAM_AW-1:0] idx;

    assign idx = addr_i.f.offset[2 +: RAM_AW];  // word index, byte bits dropped

    ////////////////////
    // byte lane writes
    ////////////////////
    always_ff @(posedge clk) begin
        if (en_i) begin
            for (int b = 0; b < 4; b++) begin
                if (we_i[b]) begin
                    mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    // read returns the old word on a collision
    always_ff @(posedge clk) begin
        if (en_i) begin
            rdata_o <= mem[idx];
        end
    end

endmodule

/* hdl/machine_timer.sv */
module machine_timer
    import soc_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n_i,
    input  logic        en_i,
    input  logic [3:0]  we_i,
    input  bus_addr_u   addr_i,
    input  logic [31:0] wdata_i,
    output logic [31:0] rdata_o,
    output logic        mti_o
);

    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic        wr;

    assign wr = en_i && (we_i != 4'h0);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mtime    <= '0;
            mtimecmp <= '1;   // no interrupt until software programs it
            mti_o    <= 1'b0;
        end else begin
            mtime <= mtime + 64'd1;
            if (wr) begin
                case (addr_i.f.offset)
                    MTIME_LO:    mtime[31:0]     <= wdata_i;
                    MTIME_HI:    mtime[63:32]    <= wdata_i;
                    MTIMECMP_LO: mtimecmp[31:0]  <= wdata_i;
                    MTIMECMP_HI: mtimecmp[63:32] <= wdata_i;
                    default: ;
                endcase
            end
            mti_o <= (mtime >= mtimecmp);  // level, stays up until cmp moves
        end
    end

    // read half select
    always_ff @(posedge clk) begin
        if (en_i) begin
            case (addr_i.f.offset)
                MTIME_LO:    rdata_o <= mtime[31:0];
                MTIME_HI:    rdata_o <= mtime[63:32];
                MTIMECMP_LO: rdata_o <= mtimecmp[31:0];
                MTIMECMP_HI: rdata_o <= mtimecmp[63:32];
                default:     rdata_o <= '0;
            endcase
        end
    end

endmodule

/* hdl/irq_controller.sv */
module irq_controller
    import soc_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 en_i,
    input  logic [3:0]           we_i,
    input  bus_addr_u            addr_i,
    input  logic [31:0]          wdata_i,
    output logic [31:0]          rdata_o,
    input  logic [IRQ_COUNT:1]   src_pulse_i,
    input  logic                 iack_i,
    output logic                 mei_o
);

    logic [IRQ_COUNT:1] pending, enable, active, clr_mask;
    logic [IRQ_ID_W-1:0] claim_id;

    assign active = pending & enable;

    // fixed priority, lowest source number wins
    always_comb begin
        claim_id = '0;
        for (int i = IRQ_COUNT; i >= 1; i--) begin
            if (active[i]) claim_id = IRQ_ID_W'(i);
        end
    end

    always_comb begin
        for (int i = 1; i <= IRQ_COUNT; i++) begin
            clr_mask[i] = iack_i && (claim_id == IRQ_ID_W'(i));
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending <= '0;
            enable  <= '0;
            mei_o   <= 1'b0;
        end else begin
            pending <= (pending & ~clr_mask) | src_pulse_i;  // new pulse beats ack
            if (en_i && (we_i != 4'h0) && addr_i.f.offset == IRQ_ENABLE) begin
                enable <= wdata_i[IRQ_COUNT:1];
            end
            mei_o <= |active;
        end
    end

    // bit 0 is unused so bit n means source n
    always_ff @(posedge clk) begin
        if (en_i) begin
            case (addr_i.f.offset)
                IRQ_ENABLE:  rdata_o <= 32'({enable, 1'b0});
                IRQ_PENDING: rdata_o <= 32'({pending, 1'b0});
                IRQ_CLAIM:   rdata_o <= 32'(claim_id);
                default:     rdata_o <= '0;
            endcase
        end
    end

endmodule

/* hdl/bus_decoder.sv */
module bus_decoder
    import soc_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n_i,
    input  logic        bus_en_i,
    input  bus_addr_u   bus_addr_i,
    output logic        ram_en_o,
    output logic        timer_en_o,
    output logic        irq_en_o,
    output logic        periph_en_o,
    input  logic [31:0] ram_rdata_i,
    input  logic [31:0] timer_rdata_i,
    input  logic [31:0] irq_rdata_i,
    input  logic [31:0] periph_rdata_i,
    output logic [31:0] bus_rdata_o
);

    logic timer_sel_q, irq_sel_q, periph_sel_q;

    // region decode, one enable per access
    always_comb begin
        ram_en_o    = 1'b0;
        timer_en_o  = 1'b0;
        irq_en_o    = 1'b0;
        periph_en_o = 1'b0;
        if (bus_en_i) begin
            if (bus_addr_i.f.region <= REGION_RAM_MAX) begin
                ram_en_o = 1'b1;
            end else if (bus_addr_i.f.region == REGION_TIMER) begin
                timer_en_o = 1'b1;
            end else if (bus_addr_i.f.region <= REGION_IRQ_MAX) begin
                irq_en_o = 1'b1;
            end else begin
                periph_en_o = 1'b1;
            end
        end
    end

    // remember who answered, data shows up next cycle
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            timer_sel_q  <= 1'b0;
            irq_sel_q    <= 1'b0;
            periph_sel_q <= 1'b0;
        end else begin
            timer_sel_q  <= timer_en_o;
            irq_sel_q    <= irq_en_o;
            periph_sel_q <= periph_en_o;
        end
    end

    always_comb begin
        if (timer_sel_q)       bus_rdata_o = timer_rdata_i;
        else if (irq_sel_q)    bus_rdata_o = irq_rdata_i;
        else if (periph_sel_q) bus_rdata_o = periph_rdata_i;
        else                   bus_rdata_o = ram_rdata_i;  // ram is the default
    end

endmodule

/* hdl/soc_platform.sv */
module soc_platform
    import soc_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n_i,
    input  logic        bus_en_i,
    input  logic [3:0]  bus_we_i,
    input  bus_addr_u   bus_addr_i,
    input  logic [31:0] bus_wdata_i,
    output logic [31:0] bus_rdata_o,
    input  logic        btn_i,
    input  logic        iack_i,
    output logic        tx_o,
    output logic        mti_o,
    output logic        mei_o
);

    logic        ram_en, timer_en, irq_en, periph_en;
    logic [31:0] ram_rdata, timer_rdata, irq_rdata, periph_rdata;
    logic        uart_done, btn_press;

    ////////////////////
    // address decode
    ////////////////////
    bus_decoder u_decoder (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .bus_en_i       (bus_en_i),
        .bus_addr_i     (bus_addr_i),
        .ram_en_o       (ram_en),
        .timer_en_o     (timer_en),
        .irq_en_o       (irq_en),
        .periph_en_o    (periph_en),
        .ram_rdata_i    (ram_rdata),
        .timer_rdata_i  (timer_rdata),
        .irq_rdata_i    (irq_rdata),
        .periph_rdata_i (periph_rdata),
        .bus_rdata_o    (bus_rdata_o)
    );

    scratch_ram u_ram (
        .clk     (clk),
        .en_i    (ram_en),
        .we_i    (bus_we_i),
        .addr_i  (bus_addr_i),
        .wdata_i (bus_wdata_i),
        .rdata_o (ram_rdata)
    );

    machine_timer u_timer (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .en_i     (timer_en),
        .we_i     (bus_we_i),
        .addr_i   (bus_addr_i),
        .wdata_i  (bus_wdata_i),
        .rdata_o  (timer_rdata),
        .mti_o    (mti_o)
    );

    // source 1 uart done, source 2 button
    irq_controller u_irq (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .en_i        (irq_en),
        .we_i        (bus_we_i),
        .addr_i      (bus_addr_i),
        .wdata_i     (bus_wdata_i),
        .rdata_o     (irq_rdata),
        .src_pulse_i ({btn_press, uart_done}),
        .iack_i      (iack_i),
        .mei_o       (mei_o)
    );

    periph_regs u_periph (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .en_i        (periph_en),
        .we_i        (bus_we_i),
        .addr_i      (bus_addr_i),
        .wdata_i     (bus_wdata_i),
        .rdata_o     (periph_rdata),
        .btn_i       (btn_i),
        .tx_o        (tx_o),
        .uart_done_o (uart_done),
        .btn_press_o (btn_press)
    );

endmodule

/* tests/tb_soc_platform.sv */
module tb_soc_platform
    import soc_pkg::*;
;

    localparam logic [1:0]  OP_WR    = 2'd0;
    localparam logic [1:0]  OP_RD_EQ = 2'd1;
    localparam logic [1:0]  OP_RD_GT = 2'd2;   // must exceed the previous read
    localparam logic [31:0] TIMER_BASE  = 32'h2000_0000;
    localparam logic [31:0] IRQ_BASE    = 32'h3000_0000;
    localparam logic [31:0] PERIPH_BASE = 32'h8000_0000;
    localparam int          WAIT_LIMIT  = 30 * CLKS_PER_BIT;

    typedef struct packed {
        logic [1:0]  kind;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [31:0] exp;
    } entry_t;

    logic        clk, arst_n_i, bus_en_i, btn_i, iack_i;
    logic [3:0]  bus_we_i;
    logic [31:0] bus_addr_i, bus_wdata_i, bus_rdata_o, last_rd;
    logic        tx_o, mti_o, mei_o;
    entry_t      table_q[$];
    logic [7:0]  rx_q[$];
    logic [7:0]  rx_byte;
    logic        rx_active;
    int          rx_cnt, rx_bit;
    integer      seed;

    soc_platform u_dut (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .bus_en_i    (bus_en_i),
        .bus_we_i    (bus_we_i),
        .bus_addr_i  (bus_addr_i),
        .bus_wdata_i (bus_wdata_i),
        .bus_rdata_o (bus_rdata_o),
        .btn_i       (btn_i),
        .iack_i      (iack_i),
        .tx_o        (tx_o),
        .mti_o       (mti_o),
        .mei_o       (mei_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////
    // reporting
    ////////////////////
    task automatic report_error(input string msg);
        $display("ERR %0t %s", $time, msg);
        $display("TEST FAIL");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic timed_out(input string what);
        $display("timed out at %0t while waiting for %s", $time, what);
        $display("TEST FAIL");
        $fatal(1, "stopped on timeout");
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                              input bit greater, input string what);
        if (greater && !(got > exp))
            report_error($sformatf("%s read 0x%08h, not above 0x%08h", what, got, exp));
        else if (!greater && got !== exp)
            report_error($sformatf("%s read 0x%08h, expected 0x%08h", what, got, exp));
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
            report_error($sformatf("uart byte 0x%02h, expected 0x%02h", got, exp));
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp)
            report_error($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    ////////////////////
    // bus master
    ////////////////////
    task automatic bus_access(input logic [31:0] addr, input logic [3:0] strb,
                              input logic [31:0] data, output logic [31:0] rdata);
        @(posedge clk);
        bus_en_i    <= 1'b1;
        bus_we_i    <= strb;
        bus_addr_i  <= addr;
        bus_wdata_i <= data;
        @(posedge clk);
        bus_en_i <= 1'b0;
        bus_we_i <= 4'h0;
        @(negedge clk);   // read word settled a cycle after the access
        rdata = bus_rdata_o;
    endtask

    task automatic add_entry(input logic [1:0] kind, input logic [31:0] addr,
                             input logic [31:0] data, input logic [3:0] strb,
                             input logic [31:0] exp);
        table_q.push_back('{kind, addr, data, strb, exp});
    endtask

    task automatic run_table();
        entry_t      e;
        logic [31:0] rd;
        while (table_q.size() != 0) begin
            e = table_q.pop_front();
            bus_access(e.addr, (e.kind == OP_WR) ? e.strb : 4'h0, e.data, rd);
            if (e.kind == OP_RD_EQ)
                check_word(rd, e.exp, 1'b0, $sformatf("addr 0x%08h", e.addr));
            else if (e.kind == OP_RD_GT)
                check_word(rd, last_rd, 1'b1, $sformatf("addr 0x%08h", e.addr));
            if (e.kind != OP_WR) last_rd = rd;
        end
    endtask

    // repeated reads until the masked word matches
    task automatic poll_read(input logic [31:0] addr, input logic [31:0] mask,
                             input logic [31:0] want, input string what);
        logic [31:0] rd;
        int          n;
        n = 0;
        bus_access(addr, 4'h0, 32'h0, rd);
        while ((rd & mask) !== want) begin
            if (n == WAIT_LIMIT) timed_out(what);
            bus_access(addr, 4'h0, 32'h0, rd);
            n++;
        end
    endtask

    task automatic wait_irq_line(input bit use_mei, input logic level, input string what);
        int n;
        n = 0;
        while ((use_mei ? mei_o : mti_o) !== level) begin
            if (n == WAIT_LIMIT) timed_out(what);
            @(negedge clk);
            n++;
        end
    endtask

    task automatic wait_rx_byte();
        int n;
        n = 0;
        while (rx_q.size() == 0) begin
            if (n == WAIT_LIMIT) timed_out("a byte on the uart line");
            @(negedge clk);
            n++;
        end
    endtask

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0] strb);
        logic [31:0] w;
        w = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) w[8*b +: 8] = new_w[8*b +: 8];
        end
        return w;
    endfunction

    ////////////////////
    // serial monitor
    ////////////////////
    always @(negedge clk) begin
        if (!arst_n_i) begin
            rx_active = 1'b0;
        end else if (!rx_active) begin
            if (tx_o === 1'b0) begin   // start bit edge
                rx_active = 1'b1;
                rx_cnt    = 0;
            end
        end else begin
            rx_cnt++;
            if (rx_cnt % CLKS_PER_BIT == CLKS_PER_BIT / 2) begin   // bit centre
                rx_bit = rx_cnt / CLKS_PER_BIT;
                if (rx_bit == 0) begin
                    check_level(tx_o, 1'b0, "uart start bit");
                end else if (rx_bit <= 8) begin
                    rx_byte[rx_bit-1] = tx_o;   // lsb first
                end else begin
                    check_level(tx_o, 1'b1, "uart stop bit");
                    rx_q.push_back(rx_byte);
                    rx_active = 1'b0;
                end
            end
        end
    end

    initial begin
        logic [31:0] ram_addr [4];
        logic [31:0] ram_exp [4];
        logic [31:0] w0, w1;
        logic [3:0]  strb;
        seed        = 32'h41e46ef8;
        arst_n_i    = 1'b0;
        bus_en_i    = 1'b0;
        bus_we_i    = 4'h0;
        bus_addr_i  = 32'h0;
        bus_wdata_i = 32'h0;
        btn_i       = 1'b0;
        iack_i      = 1'b0;
        last_rd     = 32'h0;
        rx_active   = 1'b0;
        repeat (10) @(posedge clk);
        arst_n_i <= 1'b1;
        @(negedge clk);

        // reset state
        check_level(tx_o, 1'b1, "tx_o after reset");
        check_level(mti_o, 1'b0, "mti_o after reset");
        check_level(mei_o, 1'b0, "mei_o after reset");
        add_entry(OP_RD_EQ, TIMER_BASE | 32'(MTIMECMP_LO), 32'h0, 4'h0, 32'hffff_ffff);
        run_table();

        // scratch ram over both ram regions with full then partial strobes
        for (int i = 0; i < 4; i++) begin
            ram_addr[i] = ((i % 2) ? 32'h1000_0000 : 32'h0) | 32'(i * 36);
            w0   = $random(seed);
            w1   = $random(seed);
            strb = {1'b0, 3'($random(seed))} | 4'b0001;
            ram_exp[i] = merge_bytes(w0, w1, strb);
            add_entry(OP_WR, ram_addr[i], w0, 4'hf, 32'h0);
            add_entry(OP_WR, ram_addr[i], w1, strb, 32'h0);
        end
        for (int i = 0; i < 4; i++) add_entry(OP_RD_EQ, ram_addr[i], 32'h0, 4'h0, ram_exp[i]);
        run_table();

        ////////////////////
        // machine timer
        ////////////////////
        add_entry(OP_RD_EQ, TIMER_BASE | 32'(MTIME_HI), 32'h0, 4'h0, 32'h0);
        add_entry(OP_RD_GT, TIMER_BASE | 32'(MTIME_LO), 32'h0, 4'h0, 32'h0);
        add_entry(OP_RD_GT, TIMER_BASE | 32'(MTIME_LO), 32'h0, 4'h0, 32'h0);
        add_entry(OP_WR, TIMER_BASE | 32'(MTIMECMP_HI), 32'h0, 4'hf, 32'h0);
        add_entry(OP_WR, TIMER_BASE | 32'(MTIMECMP_LO), 32'h0, 4'hf, 32'h0);
        run_table();
        wait_irq_line(1'b0, 1'b1, "mti_o to rise");
        add_entry(OP_WR, TIMER_BASE | 32'(MTIMECMP_LO), 32'hffff_ffff, 4'hf, 32'h0);
        add_entry(OP_WR, TIMER_BASE | 32'(MTIMECMP_HI), 32'hffff_ffff, 4'hf, 32'h0);
        run_table();
        wait_irq_line(1'b0, 1'b0, "mti_o to fall");

        ////////////////////
        // uart with source 1 enabled first
        ////////////////////
        add_entry(OP_WR, IRQ_BASE | 32'(IRQ_ENABLE), 32'h2, 4'hf, 32'h0);
        add_entry(OP_WR, PERIPH_BASE | 32'(UART_DATA), 32'ha5, 4'h1, 32'h0);
        add_entry(OP_RD_EQ, PERIPH_BASE | 32'(UART_STATUS), 32'h0, 4'h0, 32'h1);
        add_entry(OP_WR, PERIPH_BASE | 32'(UART_DATA), 32'h3c, 4'h1, 32'h0);  // dropped
        add_entry(OP_RD_EQ, PERIPH_BASE | 32'(UART_DATA), 32'h0, 4'h0, 32'ha5);
        run_table();
        check_level(mei_o, 1'b0, "mei_o during frame");
        wait_rx_byte();
        check_byte(rx_q.pop_front(), 8'ha5);
        wait_irq_line(1'b1, 1'b1, "mei_o after uart done");
        poll_read(PERIPH_BASE | 32'(UART_STATUS), 32'h1, 32'h0, "uart status idle");
        for (int i = 0; i < 12 * CLKS_PER_BIT; i++) begin
            @(negedge clk);
            check_level(tx_o, 1'b1, "tx_o after the frame");
        end
        if (rx_q.size() != 0) report_error("uart sent a byte written while busy");

        // interrupt claim, ack and masking
        add_entry(OP_RD_EQ, IRQ_BASE | 32'(IRQ_CLAIM), 32'h0, 4'h0, 32'h1);
        run_table();
        @(posedge clk);
        iack_i <= 1'b1;
        @(posedge clk);
        iack_i <= 1'b0;
        wait_irq_line(1'b1, 1'b0, "mei_o to fall after iack");
        @(posedge clk);
        btn_i <= 1'b1;
        poll_read(IRQ_BASE | 32'(IRQ_PENDING), 32'h4, 32'h4, "button pending bit");
        check_level(mei_o, 1'b0, "mei_o with source 2 masked");
        add_entry(OP_RD_EQ, IRQ_BASE | 32'(IRQ_PENDING), 32'h0, 4'h0, 32'h4);
        add_entry(OP_WR, IRQ_BASE | 32'(IRQ_ENABLE), 32'h6, 4'hf, 32'h0);
        run_table();
        wait_irq_line(1'b1, 1'b1, "mei_o after enabling source 2");
        add_entry(OP_RD_EQ, IRQ_BASE | 32'(IRQ_CLAIM), 32'h0, 4'h0, 32'h2);
        add_entry(OP_RD_EQ, PERIPH_BASE | 32'(BUTTON), 32'h0, 4'h0, 32'h1);
        run_table();
        @(posedge clk);
        btn_i <= 1'b0;

        $display("TEST PASS");
        $finish;
    end

endmodule

/* soc_platform.f */
hdl/soc_pkg.sv
hdl/baud_timer.sv
hdl/uart_tx_fsm.sv
hdl/periph_regs.sv
hdl/scratch_ram.sv
hdl/machine_timer.sv
hdl/irq_controller.sv
hdl/bus_decoder.sv
hdl/soc_platform.sv
tests/tb_soc_platform.sv
